// ==== sim.f ====
+incdir+include
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/csr_access_ctrl.sv
hdl/csr_trap_regs.sv
hdl/csr_perf_counters.sv
hdl/csr_file_top.sv
verif/csr_file_sva.sv
verif/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module csr_file_tb -o csr_file_sim &&
./obj_dir/csr_file_sim ||
{ echo "simulation did not pass"; exit 1; }

// ==== verif/csr_file_tb.sv ====
`include "csr_defs.svh"

module csr_file_tb
  import csr_pkg::*;
  import trap_pkg::*;
();

  typedef struct packed {
    logic id_valid;
    logic ld_stall;
    logic mem_load;
    logic mem_store;
    logic jump;
    logic branch;
    logic branch_taken;
  } ev_in_t;

  typedef struct packed {
    logic       access;
    csr_addr_t  addr;
    csr_op_e    op;
    csr_data_t  wdata;
    trap_req_t  trap;
    ev_in_t     ev;
    logic [7:0] hold;
    csr_data_t  exp;
  } row_t;

  localparam ev_in_t    ev_none   = 7'b0000000;
  localparam ev_in_t    ev_load   = 7'b0010000;
  localparam ev_in_t    ev_store  = 7'b0001000;
  localparam cause_t    irq_cause = 6'h2B;
  localparam trap_req_t no_trap   = '0;
  localparam trap_req_t trap_if   = {1'b1, 1'b1, 1'b0, 1'b0, irq_cause};
  localparam trap_req_t trap_id   = {1'b1, 1'b0, 1'b1, 1'b0, 6'h02};
  localparam trap_req_t trap_mret = {1'b0, 1'b0, 1'b0, 1'b1, 6'h00};
  localparam csr_data_t mie_mask  = csr_data_t'(1) << `MSTATUS_MIE_BIT;
  localparam csr_data_t mpie_mask = csr_data_t'(1) << `MSTATUS_MPIE_BIT;
  localparam csr_data_t ones      = 32'hFFFF_FFFF;

  logic       clk;
  logic       rst_n;
  logic       csr_access;
  csr_addr_t  csr_addr;
  csr_op_e    csr_op;
  csr_data_t  csr_wdata;
  csr_data_t  csr_rdata;
  logic [3:0] core_id;
  logic [5:0] cluster_id;
  csr_data_t  boot_addr;
  trap_req_t  trap_req;
  csr_data_t  pc_if;
  csr_data_t  pc_id;
  csr_data_t  mepc;
  logic       irq_en;
  ev_in_t     ev;

  logic [15:0] lfsr_state;
  string       names[$];
  row_t        rows[$];
  bit          table_ready;

  csr_file_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_access_i   (csr_access),
    .csr_addr_i     (csr_addr),
    .csr_op_i       (csr_op),
    .csr_wdata_i    (csr_wdata),
    .csr_rdata_o    (csr_rdata),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .boot_addr_i    (boot_addr),
    .trap_req_i     (trap_req),
    .pc_if_i        (pc_if),
    .pc_id_i        (pc_id),
    .mepc_o         (mepc),
    .m_irq_enable_o (irq_en),
    .id_valid_i     (ev.id_valid),
    .ld_stall_i     (ev.ld_stall),
    .mem_load_i     (ev.mem_load),
    .mem_store_i    (ev.mem_store),
    .jump_i         (ev.jump),
    .branch_i       (ev.branch),
    .branch_taken_i (ev.branch_taken)
  );

  bind csr_trap_regs csr_file_sva sva0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .trap_req_i     (trap_req_i),
    .status_o       (status_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 16 bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic csr_data_t rand_word(input int nbits);
    csr_data_t w;
    w = '0;
    for (int b = 0; b < nbits; b++) begin
      w = {w[30:0], lfsr_step()};
    end
    return w;
  endfunction

  task automatic add_row(input string name, input logic access, input csr_addr_t addr,
                         input csr_op_e op, input csr_data_t wdata, input trap_req_t trap,
                         input ev_in_t evs, input int hold, input csr_data_t exp);
    row_t r;
    r = '{access, addr, op, wdata, trap, evs, 8'(hold), exp};
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic report_mismatch(input string name, input csr_data_t exp,
                                 input csr_data_t act);
    $display("ERROR %s: expected %h actual %h", name, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    csr_data_t val;
    csr_data_t mask;
    csr_data_t all_val;
    csr_data_t hartid;
    csr_data_t mtvec;
    int        n_load;
    val     = rand_word(32);
    mask    = rand_word(32);
    all_val = rand_word(32);
    n_load  = 2 + int'(rand_word(3));
    // cluster id sits at bit 5 upwards, core id in the low nibble
    hartid  = (csr_data_t'(cluster_id) << 5) | csr_data_t'(core_id);
    mtvec   = (boot_addr & 32'hFFFF_FF00) | csr_data_t'(`MTVEC_MODE);

    // reset state
    add_row("mstatus reset", 1, `CSR_MSTATUS, NONE, 0, no_trap, ev_none, 0, 0);
    add_row("pcmr reset", 1, `CSR_PCMR, NONE, 0, no_trap, ev_none, 0, 32'h3);
    add_row("pcer reset", 1, `CSR_PCER, NONE, 0, no_trap, ev_none, 0, 0);
    add_row("pccr6 reset", 1, `CSR_PCCR_BASE + 12'd6, NONE, 0, no_trap, ev_none, 0, 0);
    // only mie and mpie stick in mstatus
    add_row("mstatus write", 1, `CSR_MSTATUS, WRITE, ones, no_trap, ev_none, 0,
            mie_mask | mpie_mask);
    add_row("mstatus clear", 1, `CSR_MSTATUS, CLEAR, mie_mask, no_trap, ev_none, 0, mpie_mask);
    add_row("mstatus set", 1, `CSR_MSTATUS, SET, mie_mask, no_trap, ev_none, 0,
            mie_mask | mpie_mask);
    add_row("mhartid", 1, `CSR_MHARTID, NONE, 0, no_trap, ev_none, 0, hartid);
    add_row("mtvec ro", 1, `CSR_MTVEC, WRITE, rand_word(32), no_trap, ev_none, 0, mtvec);
    add_row("mepc write", 1, `CSR_MEPC, WRITE, val, no_trap, ev_none, 0, val);
    add_row("mepc set", 1, `CSR_MEPC, SET, mask, no_trap, ev_none, 0, val | mask);
    add_row("mepc clear", 1, `CSR_MEPC, CLEAR, mask, no_trap, ev_none, 0, val & ~mask);
    add_row("mepc none", 1, `CSR_MEPC, NONE, rand_word(32), no_trap, ev_none, 0, val & ~mask);
    // trap entry beats the mepc write in the same cycle
    add_row("trap if", 1, `CSR_MEPC, WRITE, rand_word(32), trap_if, ev_none, 0, pc_if);
    // interrupt flag in bit 31, code 11 below
    add_row("mcause", 1, `CSR_MCAUSE, NONE, 0, no_trap, ev_none, 0, 32'h8000_000B);
    add_row("mstatus trap", 1, `CSR_MSTATUS, NONE, 0, no_trap, ev_none, 0, mpie_mask);
    add_row("mret", 1, `CSR_MSTATUS, NONE, 0, trap_mret, ev_none, 0, mie_mask | mpie_mask);
    add_row("trap id", 1, `CSR_MEPC, NONE, 0, trap_id, ev_none, 0, pc_id);
    add_row("mstatus trap id", 1, `CSR_MSTATUS, NONE, 0, no_trap, ev_none, 0, mpie_mask);
    add_row("mret id", 1, `CSR_MSTATUS, NONE, 0, trap_mret, ev_none, 0, mie_mask | mpie_mask);
    // load counter
    add_row("pcer load", 1, `CSR_PCER, WRITE, 32'h1 << `EV_LOAD, no_trap, ev_none, 0,
            32'h1 << `EV_LOAD);
    add_row("pccr3 clear", 1, `CSR_PCCR_BASE + 12'd3, WRITE, 0, no_trap, ev_none, 0, 0);
    add_row("load count", 1, `CSR_PCCR_BASE + 12'd3, NONE, 0, no_trap, ev_load, n_load,
            csr_data_t'(n_load));
    add_row("store disabled", 1, `CSR_PCCR_BASE + 12'd4, NONE, 0, no_trap, ev_store, 4, 0);
    add_row("pccr3 saturate", 1, `CSR_PCCR_BASE + 12'd3, WRITE, ones, no_trap, ev_load, 3,
            ones);
    add_row("pcmr wrap", 1, `CSR_PCMR, WRITE, 32'h1, no_trap, ev_none, 0, 32'h1);
    add_row("pccr3 wrap", 1, `CSR_PCCR_BASE + 12'd3, WRITE, ones, no_trap, ev_load, 1, 0);
    add_row("pccr all", 1, `CSR_PCCR_ALL, WRITE, all_val, no_trap, ev_none, 0, 0);
    add_row("pccr5 all", 1, `CSR_PCCR_BASE + 12'd5, NONE, 0, no_trap, ev_none, 0, all_val);
    add_row("pccr0 all", 1, `CSR_PCCR_BASE, NONE, 0, no_trap, ev_none, 0, all_val);
    // counter block hidden without an access
    add_row("pccr5 no access", 0, `CSR_PCCR_BASE + 12'd5, NONE, 0, no_trap, ev_none, 0, 0);
    add_row("pcer no access", 0, `CSR_PCER, NONE, 0, no_trap, ev_none, 0, 0);
    add_row("unknown addr", 1, 12'h123, NONE, 0, no_trap, ev_none, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_state = 16'd46894;
    rst_n      = 1'b0;
    csr_access = 1'b0;
    csr_addr   = '0;
    csr_op     = NONE;
    csr_wdata  = '0;
    trap_req   = '0;
    ev         = '0;
    core_id    = 4'h5;
    cluster_id = 6'h2A;
    boot_addr  = 32'h1C00_8080;
    pc_if      = rand_word(32) & ~32'h3;
    pc_id      = rand_word(32) & ~32'h3;
    build_table();
    table_ready = 1'b1;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      csr_access <= rows[i].access;
      csr_addr   <= rows[i].addr;
      csr_op     <= rows[i].op;
      csr_wdata  <= rows[i].wdata;
      trap_req   <= rows[i].trap;
      @(posedge clk);
      csr_op   <= NONE;
      trap_req <= '0;
      ev       <= rows[i].ev;
      repeat (rows[i].hold) @(posedge clk);
      ev <= '0;
      // increments land one edge after the event is sampled
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (csr_rdata == rows[i].exp)
        else report_mismatch(names[i], rows[i].exp, csr_rdata);
      // mepc and mie also show on their own outputs
      if (rows[i].addr == `CSR_MEPC) begin
        assert (mepc == rows[i].exp)
          else report_mismatch({names[i], " mepc_o"}, rows[i].exp, mepc);
      end
      if (rows[i].addr == `CSR_MSTATUS) begin
        assert (irq_en == rows[i].exp[`MSTATUS_MIE_BIT])
          else report_mismatch({names[i], " m_irq_enable_o"},
                               csr_data_t'(rows[i].exp[`MSTATUS_MIE_BIT]),
                               csr_data_t'(irq_en));
      end
    end

    $display("Test completed successfully");
    $finish;
  end

  // run length follows the table
  initial begin
    int limit;
    wait (table_ready);
    limit = 8 + 50;
    foreach (rows[k]) begin
      limit += int'(rows[k].hold) + 5;
    end
    #(limit * 10);
    $display("watchdog expired, run did not finish within %0d cycles", limit);
    $display("Test failed");
    $fatal(1);
  end

endmodule

// ==== verif/csr_file_sva.sv ====
module csr_file_sva
  import trap_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input trap_req_t trap_req_i,
  input status_t   status_o,
  input logic      m_irq_enable_o
);

  // trap entry masks interrupts at the next edge
  assert property (@(posedge clk) disable iff (!rst_n)
    trap_req_i.save_cause |=> !m_irq_enable_o)
    else $error("mie still set one cycle after trap entry");

  // entry and return never overlap
  assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_req_i.save_cause && trap_req_i.mret))
    else $error("save_cause and mret high in the same cycle");

  // mret brings mie back from mpie
  assert property (@(posedge clk) disable iff (!rst_n)
    trap_req_i.mret |=> m_irq_enable_o == $past(status_o.mpie))
    else $error("mie not restored from mpie after mret");

endmodule

// ==== hdl/csr_file_top.sv ====
module csr_file_top
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       csr_access_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_op_e    csr_op_i,
  input  csr_data_t  csr_wdata_i,
  output csr_data_t  csr_rdata_o,
  input  logic [3:0] core_id_i,
  input  logic [5:0] cluster_id_i,
  input  csr_data_t  boot_addr_i,
  input  trap_req_t  trap_req_i,
  input  csr_data_t  pc_if_i,
  input  csr_data_t  pc_id_i,
  output csr_data_t  mepc_o,
  output logic       m_irq_enable_o,
  input  logic       id_valid_i,
  input  logic       ld_stall_i,
  input  logic       mem_load_i,
  input  logic       mem_store_i,
  input  logic       jump_i,
  input  logic       branch_i,
  input  logic       branch_taken_i
);

  trap_wr_t   trap_wr;
  perf_wr_t   perf_wr;
  status_t    status;
  cause_t     mcause;
  csr_data_t  perf_rdata;
  perf_ev_t   pcer;
  logic [1:0] pcmr;

  csr_access_ctrl ctrl0 (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .status_i     (status),
    .mepc_i       (mepc_o),
    .mcause_i     (mcause),
    .perf_rdata_i (perf_rdata),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .trap_wr_o    (trap_wr),
    .perf_wr_o    (perf_wr),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs trap0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .trap_wr_i      (trap_wr),
    .trap_req_i     (trap_req_i),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .status_o       (status),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .m_irq_enable_o (m_irq_enable_o)
  );

  // counter read select follows the decoded index
  csr_perf_counters perf0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .perf_wr_i      (perf_wr),
    .pccr_idx_i     (perf_wr.pccr_idx),
    .id_valid_i     (id_valid_i),
    .ld_stall_i     (ld_stall_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .perf_rdata_o   (perf_rdata),
    .pcer_o         (pcer),
    .pcmr_o         (pcmr)
  );

endmodule

// ==== hdl/csr_perf_counters.sv ====
`include "csr_defs.svh"

module csr_perf_counters
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  perf_wr_t   perf_wr_i,
  input  perf_idx_t  pccr_idx_i,
  input  logic       id_valid_i,
  input  logic       ld_stall_i,
  input  logic       mem_load_i,
  input  logic       mem_store_i,
  input  logic       jump_i,
  input  logic       branch_i,
  input  logic       branch_taken_i,
  output csr_data_t  perf_rdata_o,
  output perf_ev_t   pcer_o,
  output logic [1:0] pcmr_o
);

  logic                        id_valid_q;
  perf_ev_t                    ev;
  perf_ev_t                    inc;
  perf_ev_t                    inc_q;
  perf_ev_t                    pcer_q;
  perf_ev_t                    pcer_d;
  logic [1:0]                  pcmr_q;
  logic [1:0]                  pcmr_d;
  csr_data_t [`N_PERF_CNT-1:0] cnt_q;
  csr_data_t [`N_PERF_CNT-1:0] cnt_d;

  ////////////////////////////////////////////////////////////////////////////
  // events
  ////////////////////////////////////////////////////////////////////////////

  assign ev[`EV_CYCLE]    = 1'b1;
  assign ev[`EV_INSTR]    = id_valid_i;
  // control flow and stalls belong to the instruction that left ID
  assign ev[`EV_LD_STALL] = ld_stall_i & id_valid_q;
  assign ev[`EV_LOAD]     = mem_load_i;
  assign ev[`EV_STORE]    = mem_store_i;
  assign ev[`EV_JUMP]     = jump_i & id_valid_q;
  assign ev[`EV_BRANCH]   = branch_i & id_valid_q;
  assign ev[`EV_BR_TAKEN] = branch_i & branch_taken_i & id_valid_q;

  // per-counter enable and global enable
  assign inc = ev & pcer_q & {`N_PERF_CNT{pcmr_q[0]}};

  ////////////////////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `N_PERF_CNT; i++) begin
      cnt_d[i] = cnt_q[i];
      // pcmr[1] holds at all ones
      if (inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      if (perf_wr_i.pccr_we &&
          (perf_wr_i.pccr_all || perf_wr_i.pccr_idx == perf_idx_t'(i))) begin
        cnt_d[i] = perf_wr_i.wdata;
      end
    end
  end

  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (perf_wr_i.pcer_we) begin
      pcer_d = perf_wr_i.wdata[`N_PERF_CNT-1:0];
    end
    if (perf_wr_i.pcmr_we) begin
      pcmr_d = perf_wr_i.wdata[1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      cnt_q      <= '0;
      pcer_q     <= '0;
      // enabled and saturating out of reset
      pcmr_q     <= 2'b11;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      cnt_q      <= cnt_d;
      pcer_q     <= pcer_d;
      pcmr_q     <= pcmr_d;
    end
  end

  assign perf_rdata_o = cnt_q[pccr_idx_i];
  assign pcer_o       = pcer_q;
  assign pcmr_o       = pcmr_q;

endmodule

// ==== hdl/csr_trap_regs.sv ====
`include "csr_defs.svh"

module csr_trap_regs
  import trap_pkg::*;
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  trap_wr_t  trap_wr_i,
  input  trap_req_t trap_req_i,
  input  csr_data_t pc_if_i,
  input  csr_data_t pc_id_i,
  output status_t   status_o,
  output csr_data_t mepc_o,
  output cause_t    mcause_o,
  output logic      m_irq_enable_o
);

  status_t   status_q;
  status_t   status_d;
  csr_data_t mepc_q;
  csr_data_t mepc_d;
  cause_t    mcause_q;
  cause_t    mcause_d;
  csr_data_t exc_pc;

  // pc of the stage that took the trap
  assign exc_pc = trap_req_i.save_if ? pc_if_i : pc_id_i;

  always_comb begin
    status_d = status_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // software writes first
    if (trap_wr_i.mstatus_we) begin
      status_d.mie  = trap_wr_i.wdata[`MSTATUS_MIE_BIT];
      status_d.mpie = trap_wr_i.wdata[`MSTATUS_MPIE_BIT];
    end
    if (trap_wr_i.mepc_we) begin
      mepc_d = trap_wr_i.wdata;
    end
    if (trap_wr_i.mcause_we) begin
      mcause_d = {trap_wr_i.wdata[31], trap_wr_i.wdata[4:0]};
    end

    // trap entry and return override the write
    if (trap_req_i.save_cause) begin
      mepc_d        = exc_pc;
      mcause_d      = trap_req_i.cause;
      status_d.mpie = status_q.mie;
      status_d.mie  = 1'b0;
    end else if (trap_req_i.mret) begin
      status_d.mie  = status_q.mpie;
      status_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      status_q <= status_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign status_o       = status_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign m_irq_enable_o = status_q.mie;

endmodule

// ==== hdl/csr_access_ctrl.sv ====
`include "csr_defs.svh"

module csr_access_ctrl
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  logic       csr_access_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_op_e    csr_op_i,
  input  csr_data_t  csr_wdata_i,
  input  logic [3:0] core_id_i,
  input  logic [5:0] cluster_id_i,
  input  csr_data_t  boot_addr_i,
  input  status_t    status_i,
  input  csr_data_t  mepc_i,
  input  cause_t     mcause_i,
  input  csr_data_t  perf_rdata_i,
  input  perf_ev_t   pcer_i,
  input  logic [1:0] pcmr_i,
  output trap_wr_t   trap_wr_o,
  output perf_wr_t   perf_wr_o,
  output csr_data_t  csr_rdata_o
);

  logic      is_mstatus;
  logic      is_mtvec;
  logic      is_mepc;
  logic      is_mcause;
  logic      is_mhartid;
  logic      is_pccr;
  logic      is_pccr_all;
  logic      is_pcer;
  logic      is_pcmr;
  logic      is_perf;
  csr_data_t wdata_int;
  logic      we_int;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign is_mstatus  = csr_addr_i == `CSR_MSTATUS;
  assign is_mtvec    = csr_addr_i == `CSR_MTVEC;
  assign is_mepc     = csr_addr_i == `CSR_MEPC;
  assign is_mcause   = csr_addr_i == `CSR_MCAUSE;
  assign is_mhartid  = csr_addr_i == `CSR_MHARTID;
  // single counters occupy an aligned window above the base
  assign is_pccr     = (csr_addr_i & ~csr_addr_t'(`N_PERF_CNT - 1)) == `CSR_PCCR_BASE;
  assign is_pccr_all = csr_addr_i == `CSR_PCCR_ALL;
  assign is_pcer     = csr_addr_i == `CSR_PCER;
  assign is_pcmr     = csr_addr_i == `CSR_PCMR;
  assign is_perf     = is_pccr | is_pccr_all | is_pcer | is_pcmr;

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    if (is_mstatus) begin
      csr_rdata_o[`MSTATUS_MIE_BIT]  = status_i.mie;
      csr_rdata_o[`MSTATUS_MPIE_BIT] = status_i.mpie;
    end
    if (is_mtvec) begin
      csr_rdata_o = {boot_addr_i[31:8], 6'h0, `MTVEC_MODE};
    end
    if (is_mepc) begin
      csr_rdata_o = mepc_i;
    end
    if (is_mcause) begin
      csr_rdata_o = {mcause_i[5], 26'b0, mcause_i[4:0]};
    end
    if (is_mhartid) begin
      csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
    end
    if (is_pccr) begin
      csr_rdata_o = perf_rdata_i;
    end
    if (is_pcer) begin
      csr_rdata_o = csr_data_t'(pcer_i);
    end
    if (is_pcmr) begin
      csr_rdata_o = csr_data_t'(pcmr_i);
    end
    // counter block only shows up during a real access
    if (is_perf && !csr_access_i) begin
      csr_rdata_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // op resolution and write strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    we_int    = 1'b1;
    wdata_int = csr_wdata_i;
    case (csr_op_i)
      SET:     wdata_int = csr_wdata_i | csr_rdata_o;
      CLEAR:   wdata_int = ~csr_wdata_i & csr_rdata_o;
      NONE:    we_int    = 1'b0;
      default: wdata_int = csr_wdata_i;
    endcase
  end

  always_comb begin
    trap_wr_o          = '0;
    perf_wr_o          = '0;
    trap_wr_o.wdata    = wdata_int;
    perf_wr_o.wdata    = wdata_int;
    // index also steers the counter read mux
    perf_wr_o.pccr_idx = perf_idx_t'(csr_addr_i);
    if (we_int) begin
      trap_wr_o.mstatus_we = is_mstatus;
      trap_wr_o.mepc_we    = is_mepc;
      trap_wr_o.mcause_we  = is_mcause;
      perf_wr_o.pccr_we    = is_pccr | is_pccr_all;
      perf_wr_o.pccr_all   = is_pccr_all;
      perf_wr_o.pcer_we    = is_pcer;
      perf_wr_o.pcmr_we    = is_pcmr;
    end
  end

endmodule

// ==== hdl/trap_pkg.sv ====
package trap_pkg;
  import csr_pkg::*;

  // msb flags an interrupt, low bits hold the code
  typedef logic [5:0] cause_t;

  typedef struct packed {
    logic mpie;
    logic mie;
  } status_t;

  // requests from the controller
  typedef struct packed {
    logic   save_cause;
    logic   save_if;
    logic   save_id;
    logic   mret;
    cause_t cause;
  } trap_req_t;

  // resolved register writes for the trap side
  typedef struct packed {
    logic      mstatus_we;
    logic      mepc_we;
    logic      mcause_we;
    csr_data_t wdata;
  } trap_wr_t;

endpackage

// ==== hdl/csr_pkg.sv ====
`include "csr_defs.svh"

package csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // op encoding seen on csr_op_i
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  typedef logic [$clog2(`N_PERF_CNT)-1:0] perf_idx_t;

  // one bit per counter event
  typedef logic [`N_PERF_CNT-1:0] perf_ev_t;

  // resolved write towards the counter bank
  typedef struct packed {
    logic      pccr_we;
    logic      pccr_all;
    perf_idx_t pccr_idx;
    logic      pcer_we;
    logic      pcmr_we;
    csr_data_t wdata;
  } perf_wr_t;

endpackage

// ==== include/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// machine trap registers
`define CSR_MSTATUS      12'h300
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342
`define CSR_MHARTID      12'hF14

// performance counter block, counter i sits at base + i
`define CSR_PCCR_BASE    12'h780
`define CSR_PCCR_ALL     12'h79F
`define CSR_PCER         12'h7A0
`define CSR_PCMR         12'h7A1

// mstatus fields
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

`define N_PERF_CNT       8

// vectored trap mode
`define MTVEC_MODE       2'b01

// event order in the counter bank
`define EV_CYCLE         0
`define EV_INSTR         1
`define EV_LD_STALL      2
`define EV_LOAD          3
`define EV_STORE         4
`define EV_JUMP          5
`define EV_BRANCH        6
`define EV_BR_TAKEN      7

`endif
